// File: hw/gl_math_pkg.sv
package gl_math_pkg;

    typedef logic signed [31:0] fx_t;      // signed q16.16
    typedef fx_t [3:0]  vec4_t;            // [0] x, [1] y, [2] z, [3] w
    typedef fx_t [15:0] mat4_t;            // row-major, [4*row + col]

    localparam int  FX_FRAC = 16;
    localparam fx_t FX_ONE  = 32'sh0001_0000;
    localparam fx_t FX_SAT  = 32'sh7fff_ffff;  // divide by zero / quotient overflow

    // full 64-bit signed product, arithmetic shift back to q16.16
    // upper bits simply dropped, no saturation
    function automatic fx_t fx_mul(input fx_t a, input fx_t b);
        logic signed [63:0] p;
        p = 64'(a) * 64'(b);
        return fx_t'(p >>> FX_FRAC);
    endfunction

endpackage

// File: hw/gl_cmd_pkg.sv
package gl_cmd_pkg;

    localparam int CMD_AW    = 8;              // command ram address bits
    localparam int CMD_DEPTH = 1 << CMD_AW;

    typedef enum logic [7:0] {
        OP_LOAD_ID  = 8'h01,
        OP_LOAD_MAT = 8'h02,
        OP_VIEWPORT = 8'h03,
        OP_COLOR    = 8'h04,
        OP_VERTEX   = 8'h05,
        OP_END      = 8'hff
    } opcode_e;

    // command view of a ram word
    typedef struct packed {
        logic        is_cmd;       // set on every command word
        logic [22:0] imm;          // spare immediate, unused by current opcodes
        logic [7:0]  opcode;
    } cmd_t;

    // same word, read as command or as operand depending on decoder state
    typedef union packed {
        cmd_t             cmd;
        gl_math_pkg::fx_t data;
    } cmd_word_u;

    // operand words following each command
    localparam logic [4:0] OPN_MAT      = 5'd16;
    localparam logic [4:0] OPN_VIEWPORT = 5'd4;    // x, y, width, height
    localparam logic [4:0] OPN_VERTEX   = 5'd4;    // x, y, z, w
    localparam logic [4:0] OPN_COLOR    = 5'd1;    // 0x00rrggbb

endpackage

// File: hw/gl_xform_if.sv
interface gl_xform_if;

    gl_math_pkg::fx_t   wdata;         // operand word
    logic [3:0]         widx;          // element select
    logic               mat_we;
    logic               id_load;
    logic               vec_we;
    logic               vp_we;
    logic               col_we;
    logic               xform_start;   // pulse, vertex complete
    logic               xform_done;    // pulse, vout valid
    logic               proj_done;     // pulse, screen vertex out
    gl_math_pkg::vec4_t vout;

    modport ctrl   (output wdata, widx, mat_we, id_load, vec_we, vp_we, col_we, xform_start,
                    input proj_done);
    modport matrix (input wdata, widx, mat_we, id_load, vec_we, xform_start,
                    output xform_done, vout);
    modport proj   (input wdata, widx, vp_we, col_we, xform_done, vout,
                    output proj_done);

endinterface

// File: hw/gl_cmd_ram.sv
module gl_cmd_ram (
    input  logic                          clk1,
    input  logic                          a_en,
    input  logic                          a_we,
    input  logic [gl_cmd_pkg::CMD_AW-1:0] a_addr,
    input  logic [31:0]                   a_wdata,
    output logic [31:0]                   a_rdata,
    input  logic [gl_cmd_pkg::CMD_AW-1:0] b_addr,
    output gl_cmd_pkg::cmd_word_u         b_rdata
);

    logic [31:0] mem [gl_cmd_pkg::CMD_DEPTH];

    // port A, host side, read-first
    always_ff @(posedge clk1)
    begin
        if (a_en)
        begin
            if (a_we)
                mem[a_addr] <= a_wdata;
            a_rdata <= mem[a_addr];
        end
    end

    // port B, fetch side, read every cycle
    always_ff @(posedge clk1)
    begin
        b_rdata <= mem[b_addr];
    end

endmodule

// File: hw/gl_fetch.sv
module gl_fetch (
    input  logic                          clk1,
    input  logic                          arst_n,
    input  logic                          run_start,   // pc back to 0
    input  logic                          advance,     // next word
    input  logic                          load_ops,
    input  logic                          op_take,     // one operand consumed
    input  logic [4:0]                    ops_n,
    output logic [gl_cmd_pkg::CMD_AW-1:0] pc,
    output logic                          ops_last
);

    logic [4:0] ops_left;   // operands still to come, current one included

    // program counter
    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
            pc <= '0;
        else if (run_start)
            pc <= '0;
        else if (advance)
            pc <= pc + 1'b1;
    end

    // operand down-counter
    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
            ops_left <= '0;
        else if (load_ops)
            ops_left <= ops_n;
        else if (op_take && ops_left != '0)
            ops_left <= ops_left - 1'b1;
    end

    assign ops_last = (ops_left == 5'd1);

endmodule

// File: hw/gl_decode.sv
module gl_decode (
    input  logic                  clk1,
    input  logic                  arst_n,
    input  logic                  start,
    input  gl_cmd_pkg::cmd_word_u word,
    input  logic                  ops_last,
    output logic                  run_start,
    output logic                  advance,
    output logic                  load_ops,
    output logic                  op_take,
    output logic [4:0]            ops_n,
    output logic                  busy,
    output logic                  done,
    output logic                  fault,
    gl_xform_if.ctrl              xf
);

    typedef enum logic [2:0] {IDLE, WAIT_RD, DECODE, OPERAND, XFORM, HALT, FAULT} state_e;

    state_e     state, state_nx;
    logic       opnd;          // next word read is an operand
    logic [7:0] cur_op;        // opcode owning the operands
    logic [3:0] idx;           // element index of the operand

    //////////////////////////////
    // operand count, zero for LOAD_ID / END / unknown
    always_comb
    begin
        case (word.cmd.opcode)
            gl_cmd_pkg::OP_LOAD_MAT: ops_n = gl_cmd_pkg::OPN_MAT;
            gl_cmd_pkg::OP_VIEWPORT: ops_n = gl_cmd_pkg::OPN_VIEWPORT;
            gl_cmd_pkg::OP_COLOR:    ops_n = gl_cmd_pkg::OPN_COLOR;
            gl_cmd_pkg::OP_VERTEX:   ops_n = gl_cmd_pkg::OPN_VERTEX;
            default:                 ops_n = '0;
        endcase
    end

    //////////////////////////////
    // sequencing, every advance costs a WAIT_RD for the ram latency
    always_comb
    begin
        state_nx  = state;
        run_start = 1'b0;
        advance   = 1'b0;
        load_ops  = 1'b0;
        op_take   = 1'b0;
        case (state)
            IDLE, HALT, FAULT:
                if (start)
                begin
                    run_start = 1'b1;
                    state_nx  = WAIT_RD;
                end
            WAIT_RD:
                state_nx = opnd ? OPERAND : DECODE;
            DECODE:
                if (!word.cmd.is_cmd)
                    state_nx = FAULT;                  // data where a command belongs
                else if (word.cmd.opcode == gl_cmd_pkg::OP_END)
                    state_nx = HALT;
                else if (word.cmd.opcode == gl_cmd_pkg::OP_LOAD_ID || ops_n != '0)
                begin
                    advance  = 1'b1;
                    load_ops = (ops_n != '0);
                    state_nx = WAIT_RD;
                end
                else
                    state_nx = FAULT;                  // unknown opcode
            OPERAND:
            begin
                op_take  = 1'b1;
                advance  = 1'b1;
                state_nx = (ops_last && cur_op == gl_cmd_pkg::OP_VERTEX) ? XFORM : WAIT_RD;
            end
            XFORM:
                if (xf.proj_done)
                    state_nx = DECODE;   // pc parked for ages, word already valid
            default:
                state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state          <= IDLE;
            opnd           <= 1'b0;
            cur_op         <= '0;
            idx            <= '0;
            xf.xform_start <= 1'b0;
        end
        else
        begin
            state          <= state_nx;
            // first XFORM cycle, w is in the vector register by then
            xf.xform_start <= (state == OPERAND) && ops_last && (cur_op == gl_cmd_pkg::OP_VERTEX);
            if (run_start)
                opnd <= 1'b0;
            else if (load_ops)
            begin
                opnd   <= 1'b1;
                cur_op <= word.cmd.opcode;
                idx    <= '0;
            end
            else if (op_take)
            begin
                idx <= idx + 1'b1;
                if (ops_last)
                    opnd <= 1'b0;
            end
        end
    end

    // operand routing, data view of the word
    assign xf.wdata   = word.data;
    assign xf.widx    = idx;
    assign xf.id_load = (state == DECODE) && word.cmd.is_cmd
                        && (word.cmd.opcode == gl_cmd_pkg::OP_LOAD_ID);
    assign xf.mat_we  = (state == OPERAND) && (cur_op == gl_cmd_pkg::OP_LOAD_MAT);
    assign xf.vec_we  = (state == OPERAND) && (cur_op == gl_cmd_pkg::OP_VERTEX);
    assign xf.vp_we   = (state == OPERAND) && (cur_op == gl_cmd_pkg::OP_VIEWPORT);
    assign xf.col_we  = (state == OPERAND) && (cur_op == gl_cmd_pkg::OP_COLOR);

    assign busy  = !(state inside {IDLE, HALT, FAULT});
    assign done  = (state == HALT);
    assign fault = (state == FAULT);

endmodule

// File: hw/gl_matrix_unit.sv
module gl_matrix_unit (
    input  logic       clk1,
    input  logic       arst_n,
    gl_xform_if.matrix xf
);

    gl_math_pkg::mat4_t mat;
    gl_math_pkg::vec4_t vin;        // vertex as submitted
    logic               run;
    logic [1:0]         row;        // row summed this cycle and 0 whenever idle
    gl_math_pkg::fx_t   row_sum;

    //////////////////////////////
    // one row of M * v
    always_comb
    begin
        row_sum = '0;
        for (int k = 0; k < 4; k++)
        begin
            row_sum = row_sum + gl_math_pkg::fx_mul(mat[{row, 2'(k)}], vin[k]);
        end
    end

    always_ff @(posedge clk1)
    begin
        if (xf.id_load)
        begin
            for (int i = 0; i < 16; i++)
                mat[i] <= (i % 5 == 0) ? gl_math_pkg::FX_ONE : '0;   // diagonal
        end
        else if (xf.mat_we)
            mat[xf.widx] <= xf.wdata;
        if (xf.vec_we)
            vin[xf.widx[1:0]] <= xf.wdata;
        if (xf.xform_start || run)
            xf.vout[row] <= row_sum;
    end

    // row sequencer with done 4 cycles after start
    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run           <= 1'b0;
            row           <= '0;
            xf.xform_done <= 1'b0;
        end
        else
        begin
            xf.xform_done <= run && (row == 2'd3);
            if (xf.xform_start)
            begin
                run <= 1'b1;
                row <= 2'd1;
            end
            else if (run)
            begin
                row <= row + 1'b1;     // wraps back to 0
                if (row == 2'd3)
                    run <= 1'b0;
            end
        end
    end

endmodule

// File: hw/gl_persp_view.sv
module gl_persp_view (
    input  logic             clk1,
    input  logic             arst_n,
    gl_xform_if.proj         xf,
    output logic             vert_valid,
    output gl_math_pkg::fx_t vert_x,
    output gl_math_pkg::fx_t vert_y,
    output logic [23:0]      vert_rgb
);

    gl_math_pkg::vec4_t vp;          // x, y, width, height
    logic [23:0]        rgb;
    logic               div_run;
    logic               sel;         // 0 x/w, 1 y/w
    logic [5:0]         step;
    logic               vp_cyc;      // viewport mapping cycle
    logic [47:0]        dvd;         // |num| << 16 shifting out, quotient shifting in
    logic [31:0]        rem;
    logic [31:0]        den;         // |w|
    logic [31:0]        ny;          // |y| parked until x is through
    logic               w_neg;
    logic [1:0]         n_neg;       // numerator signs
    logic [32:0]        rem_sh, rem_sub;
    logic               qbit;
    logic [47:0]        quo;
    logic [31:0]        q_mag;
    gl_math_pkg::fx_t   q_res, ndc_x, ndc_y, half_x, half_y;

    function automatic logic [31:0] mag(input gl_math_pkg::fx_t v);
        return v[31] ? -v : v;
    endfunction

    //////////////////////////////
    // restoring divider step
    assign rem_sh  = {rem, dvd[47]};
    assign rem_sub = rem_sh - {1'b0, den};
    assign qbit    = !rem_sub[32];                 // no borrow
    assign quo     = {dvd[46:0], qbit};
    // w == 0 gives all ones here, so it saturates like any overflow
    assign q_mag   = (quo[47:31] != '0) ? gl_math_pkg::FX_SAT : quo[31:0];
    assign q_res   = (n_neg[sel] ^ w_neg) ? -q_mag : q_mag;

    // (ndc + 1) * size / 2
    always_comb
    begin
        half_x = gl_math_pkg::fx_mul(ndc_x + gl_math_pkg::FX_ONE, vp[2]) >>> 1;
        half_y = gl_math_pkg::fx_mul(ndc_y + gl_math_pkg::FX_ONE, vp[3]) >>> 1;
    end

    always_ff @(posedge clk1)
    begin
        if (xf.vp_we)
            vp[xf.widx[1:0]] <= xf.wdata;
        if (xf.col_we)
            rgb <= xf.wdata[23:0];
        if (xf.xform_done)
        begin
            dvd   <= {mag(xf.vout[0]), 16'h0};
            ny    <= mag(xf.vout[1]);
            den   <= mag(xf.vout[3]);
            n_neg <= {xf.vout[1][31], xf.vout[0][31]};
            w_neg <= xf.vout[3][31];
            rem   <= '0;
        end
        else if (div_run)
        begin
            if (step == 6'd47)
            begin
                if (sel)
                    ndc_y <= q_res;
                else
                    ndc_x <= q_res;
                dvd <= {ny, 16'h0};     // y next, same divider
                rem <= '0;
            end
            else
            begin
                dvd <= quo;
                rem <= qbit ? rem_sub[31:0] : rem_sh[31:0];
            end
        end
        if (vp_cyc)
        begin
            vert_x   <= vp[0] + half_x;
            vert_y   <= vp[1] + half_y;
            vert_rgb <= rgb;
        end
    end

    //////////////////////////////
    // control, 48 + 48 steps then one mapping cycle
    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_run    <= 1'b0;
            sel        <= 1'b0;
            step       <= '0;
            vp_cyc     <= 1'b0;
            vert_valid <= 1'b0;
        end
        else
        begin
            vert_valid <= vp_cyc;      // lines up with vert_x / vert_y
            vp_cyc     <= 1'b0;
            if (xf.xform_done)
            begin
                div_run <= 1'b1;
                sel     <= 1'b0;
                step    <= '0;
            end
            else if (div_run)
            begin
                step <= step + 1'b1;
                if (step == 6'd47)
                begin
                    step <= '0;
                    sel  <= 1'b1;
                    if (sel)
                    begin
                        div_run <= 1'b0;
                        vp_cyc  <= 1'b1;
                    end
                end
            end
        end
    end

    assign xf.proj_done = vert_valid;

endmodule

// File: hw/gl_core.sv
module gl_core (
    input  logic                          clk1,
    input  logic                          arst_n,
    input  logic                          ram_en,
    input  logic                          ram_we,
    input  logic [gl_cmd_pkg::CMD_AW-1:0] ram_addr,
    input  logic [31:0]                   ram_wdata,
    output logic [31:0]                   ram_rdata,
    input  logic                          start,
    output logic                          busy,
    output logic                          done,
    output logic                          fault,
    output logic                          vert_valid,
    output gl_math_pkg::fx_t              vert_x,
    output gl_math_pkg::fx_t              vert_y,
    output logic [23:0]                   vert_rgb
);

    gl_xform_if xf ();

    logic [gl_cmd_pkg::CMD_AW-1:0] pc;
    gl_cmd_pkg::cmd_word_u         word;       // port B read data
    logic                          run_start, advance, load_ops, op_take, ops_last;
    logic [4:0]                    ops_n;

    //////////////////////////////
    // fetch side
    gl_cmd_ram ram0 (.clk1(clk1), .a_en(ram_en), .a_we(ram_we), .a_addr(ram_addr),
                     .a_wdata(ram_wdata), .a_rdata(ram_rdata), .b_addr(pc), .b_rdata(word));

    gl_fetch fetch0 (.clk1(clk1), .arst_n(arst_n), .run_start(run_start), .advance(advance),
                     .load_ops(load_ops), .op_take(op_take), .ops_n(ops_n), .pc(pc),
                     .ops_last(ops_last));

    gl_decode decode0 (.clk1(clk1), .arst_n(arst_n), .start(start), .word(word),
                       .ops_last(ops_last), .run_start(run_start), .advance(advance),
                       .load_ops(load_ops), .op_take(op_take), .ops_n(ops_n), .busy(busy),
                       .done(done), .fault(fault), .xf(xf.ctrl));

    //////////////////////////////
    // transform and projection
    gl_matrix_unit mat0 (.clk1(clk1), .arst_n(arst_n), .xf(xf.matrix));

    gl_persp_view proj0 (.clk1(clk1), .arst_n(arst_n), .xf(xf.proj), .vert_valid(vert_valid),
                         .vert_x(vert_x), .vert_y(vert_y), .vert_rgb(vert_rgb));

endmodule

// File: testbench/tb_gl_model.svh
`ifndef TB_GL_MODEL_SVH
`define TB_GL_MODEL_SVH

typedef struct packed {
    gl_math_pkg::fx_t x;
    gl_math_pkg::fx_t y;
    logic [23:0]      rgb;
} exp_t;

exp_t             exp_q [$];        // expected screen vertices, oldest first
logic             exp_valid;        // queue front below is live
gl_math_pkg::fx_t exp_x, exp_y;
logic [23:0]      exp_rgb;
logic [31:0]      rng;
logic [gl_cmd_pkg::CMD_AW-1:0] wp; // stream write pointer
gl_math_pkg::fx_t m_mat [16];       // model copy of the core state
gl_math_pkg::fx_t m_vp [4];
logic [23:0]      m_rgb;

//////////////////////////////
// stimulus values
function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

// base + [0, span)
function automatic gl_math_pkg::fx_t range_rand(input gl_math_pkg::fx_t base,
                                                input logic [31:0] span);
    return base + $signed(next_rand() % span);
endfunction

//////////////////////////////
// q16.16 reference arithmetic
function automatic gl_math_pkg::fx_t q_mul(input gl_math_pkg::fx_t a,
                                           input gl_math_pkg::fx_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return p[47:16];                    // floor of p / 2^16, low word kept
endfunction

function automatic gl_math_pkg::fx_t q_div(input gl_math_pkg::fx_t n,
                                           input gl_math_pkg::fx_t w);
    longint           num, den, q;
    gl_math_pkg::fx_t mag_q;
    num = (n < 0) ? -longint'(n) : longint'(n);
    den = (w < 0) ? -longint'(w) : longint'(w);
    if (den == 0)
        mag_q = gl_math_pkg::FX_SAT;    // w of zero
    else
    begin
        q     = (num * 65536) / den;
        mag_q = (q > 64'sh7fff_ffff) ? gl_math_pkg::FX_SAT : q[31:0];   // overflow clamps
    end
    return (n[31] ^ w[31]) ? -mag_q : mag_q;
endfunction

task automatic refresh_front();
    exp_valid = (exp_q.size() != 0);
    if (exp_valid)
    begin
        exp_x   = exp_q[0].x;
        exp_y   = exp_q[0].y;
        exp_rgb = exp_q[0].rgb;
    end
endtask

//////////////////////////////
// command stream writers, entered and left 1 unit after a rising edge
task automatic ram_write(input logic [gl_cmd_pkg::CMD_AW-1:0] addr, input logic [31:0] data);
    ram_en    = 1'b1;
    ram_we    = 1'b1;
    ram_addr  = addr;
    ram_wdata = data;
    @(posedge clk1);
    #1;
    ram_en = 1'b0;
    ram_we = 1'b0;
endtask

task automatic put_word(input logic [31:0] data);
    ram_write(wp, data);
    wp = wp + 1'b1;
endtask

task automatic put_cmd(input gl_cmd_pkg::opcode_e op);
    put_word({1'b1, 23'h0, op});        // is_cmd set, imm unused
endtask

task automatic put_load_id();
    put_cmd(gl_cmd_pkg::OP_LOAD_ID);
    for (int i = 0; i < 16; i++)
        m_mat[i] = (i / 4 == i % 4) ? gl_math_pkg::FX_ONE : '0;
endtask

// words come from m_mat, caller fills it first
task automatic put_load_mat();
    put_cmd(gl_cmd_pkg::OP_LOAD_MAT);
    for (int i = 0; i < 16; i++)
        put_word(m_mat[i]);
endtask

task automatic put_viewport(input gl_math_pkg::fx_t x, y, w, h);
    m_vp[0] = x;
    m_vp[1] = y;
    m_vp[2] = w;
    m_vp[3] = h;
    put_cmd(gl_cmd_pkg::OP_VIEWPORT);
    for (int i = 0; i < 4; i++)
        put_word(m_vp[i]);
endtask

task automatic put_color(input logic [23:0] rgb);
    m_rgb = rgb;
    put_cmd(gl_cmd_pkg::OP_COLOR);
    put_word({8'h00, rgb});
endtask

task automatic put_end();
    put_cmd(gl_cmd_pkg::OP_END);
endtask

// vertex words, plus the expected screen vertex when one should come out
task automatic put_vertex(input gl_math_pkg::fx_t x, y, z, w, input bit expect_out);
    gl_math_pkg::fx_t v [4];
    gl_math_pkg::fx_t r [4];
    gl_math_pkg::fx_t ndx, ndy;
    exp_t             e;
    v[0] = x;
    v[1] = y;
    v[2] = z;
    v[3] = w;
    put_cmd(gl_cmd_pkg::OP_VERTEX);
    for (int k = 0; k < 4; k++)
        put_word(v[k]);
    if (expect_out)
    begin
        for (int i = 0; i < 4; i++)
        begin
            r[i] = '0;
            for (int k = 0; k < 4; k++)
                r[i] = r[i] + q_mul(m_mat[4 * i + k], v[k]);   // row i of M * v
        end
        ndx   = q_div(r[0], r[3]);
        ndy   = q_div(r[1], r[3]);
        e.x   = m_vp[0] + (q_mul(ndx + gl_math_pkg::FX_ONE, m_vp[2]) >>> 1);
        e.y   = m_vp[1] + (q_mul(ndy + gl_math_pkg::FX_ONE, m_vp[3]) >>> 1);
        e.rgb = m_rgb;
        exp_q.push_back(e);
        refresh_front();
    end
endtask

`endif

// File: testbench/tb_gl_core.sv
module tb_gl_core;

    localparam int N_VERTS   = 14;                      // vertices expected over all streams
    localparam int WD_CYCLES = 200 * N_VERTS + 2000;

    logic                          clk1;
    logic                          arst_n;
    logic                          ram_en, ram_we;
    logic [gl_cmd_pkg::CMD_AW-1:0] ram_addr;
    logic [31:0]                   ram_wdata, ram_rdata;
    logic                          start, busy, done, fault;
    logic                          vert_valid;
    gl_math_pkg::fx_t              vert_x, vert_y;
    logic [23:0]                   vert_rgb;
    logic [31:0]                   rd_word;
    logic                          pop_due;             // front was checked at the last edge

    `include "tb_gl_model.svh"

    gl_core dut0 (.clk1(clk1), .arst_n(arst_n), .ram_en(ram_en), .ram_we(ram_we),
                  .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
                  .start(start), .busy(busy), .done(done), .fault(fault),
                  .vert_valid(vert_valid), .vert_x(vert_x), .vert_y(vert_y),
                  .vert_rgb(vert_rgb));

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    initial
    begin
        clk1 = 1'b0;
        forever #5 clk1 = ~clk1;
    end

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk1);
        $display("timeout, the core did not finish within %0d cycles", WD_CYCLES);
        fail_run();
    end

    //////////////////////////////
    // output checks
    a_expected: assert property (@(posedge clk1) disable iff (!arst_n)
                                 vert_valid |-> exp_valid)
        else
        begin
            $display("vertex output seen with no vertex pending");
            fail_run();
        end
    a_vert_x: assert property (@(posedge clk1) disable iff (!arst_n)
                               vert_valid |-> vert_x == exp_x)
        else
        begin
            $display("error vert_x got %h expected %h", vert_x, exp_x);
            fail_run();
        end
    a_vert_y: assert property (@(posedge clk1) disable iff (!arst_n)
                               vert_valid |-> vert_y == exp_y)
        else
        begin
            $display("error vert_y got %h expected %h", vert_y, exp_y);
            fail_run();
        end
    a_rgb: assert property (@(posedge clk1) disable iff (!arst_n)
                            vert_valid |-> vert_rgb == exp_rgb)
        else
        begin
            $display("error vert_rgb got %h expected %h", vert_rgb, exp_rgb);
            fail_run();
        end
    a_pulse: assert property (@(posedge clk1) disable iff (!arst_n)
                              vert_valid |=> !vert_valid)
        else
        begin
            $display("vert_valid held longer than one cycle");
            fail_run();
        end
    a_idle: assert property (@(posedge clk1) disable iff (!arst_n)
                             (done || fault) |-> !busy)
        else
        begin
            $display("error busy %h with done %h fault %h", busy, done, fault);
            fail_run();
        end

    // front leaves the queue on the negedge after the edge that checked it
    always @(negedge clk1)
    begin
        if (pop_due && exp_q.size() != 0)
        begin
            exp_q.delete(0);
            refresh_front();
        end
        pop_due = arst_n && vert_valid;
    end

    // pulse start and wait for the end of the stream
    task automatic run_stream(input bit expect_fault);
        start = 1'b1;
        @(posedge clk1);
        #1;
        start = 1'b0;
        assert (busy && !done && !fault)   // busy a cycle after start with old status gone
            else
            begin
                $display("error busy %h done %h fault %h", busy, done, fault);
                fail_run();
            end
        wait (done || fault);
        @(posedge clk1);
        #1;
        if (expect_fault)
        begin
            assert (fault && !busy && !done)
                else
                begin
                    $display("error fault %h busy %h done %h", fault, busy, done);
                    fail_run();
                end
        end
        else
        begin
            assert (done && !busy && !fault)
                else
                begin
                    $display("error done %h busy %h fault %h", done, busy, fault);
                    fail_run();
                end
        end
        assert (exp_q.size() == 0)
            else
            begin
                $display("stream ended with vertices never output");
                fail_run();
            end
    endtask

    initial
    begin
        arst_n    = 1'b0;
        ram_en    = 1'b0;
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        start     = 1'b0;
        pop_due   = 1'b0;
        rng       = 32'h8f33_7334;
        wp        = '0;
        refresh_front();
        repeat (8) @(posedge clk1);
        #1 arst_n = 1'b1;

        //////////////////////////////
        // reset state and host port round trip
        assert (!busy && !done && !fault && !vert_valid)
            else
            begin
                $display("error after reset busy %h done %h fault %h vert_valid %h",
                         busy, done, fault, vert_valid);
                fail_run();
            end
        ram_write(8'hfa, 32'hc0de_5a5a);
        ram_en   = 1'b1;
        ram_addr = 8'hfa;
        @(posedge clk1);
        #1;
        ram_en  = 1'b0;
        rd_word = ram_rdata;
        assert (rd_word == 32'hc0de_5a5a)
            else
            begin
                $display("error ram_rdata got %h expected %h", rd_word, 32'hc0de_5a5a);
                fail_run();
            end

        // identity with w of one
        wp = '0;
        put_load_id();
        put_viewport(32'sh0010_0000, 32'sh0010_0000, 32'sh0140_0000, 32'sh00f0_0000);
        put_color(24'h10_20_30);
        put_vertex(32'sh0000_8000, 32'shffff_c000, '0, gl_math_pkg::FX_ONE, 1'b1);
        put_end();
        run_stream(1'b0);

        // scale and translate with 8 random vertices
        wp = '0;
        put_viewport(32'sh0008_0000, 32'sh0004_0000, 32'sh0040_0000, 32'sh0030_0000);
        put_color(24'hff_80_00);
        for (int i = 0; i < 16; i++)
            m_mat[i] = '0;
        m_mat[0]  = range_rand(32'sh0000_8000, 32'h0002_0000);   // 0.5 .. 2.5
        m_mat[5]  = range_rand(32'sh0000_8000, 32'h0002_0000);
        m_mat[10] = range_rand(32'sh0000_8000, 32'h0002_0000);
        m_mat[3]  = range_rand(32'shffc0_0000, 32'h0080_0000);   // tx within +-64
        m_mat[7]  = range_rand(32'shffc0_0000, 32'h0080_0000);
        m_mat[15] = gl_math_pkg::FX_ONE;
        put_load_mat();
        for (int n = 0; n < 8; n++)
            put_vertex(range_rand(32'shffc0_0000, 32'h0080_0000),
                       range_rand(32'shffc0_0000, 32'h0080_0000),
                       range_rand(32'shffc0_0000, 32'h0080_0000),
                       range_rand(gl_math_pkg::FX_ONE, 32'h0003_0000), 1'b1);
        put_end();
        run_stream(1'b0);

        // w of two and then w of zero
        wp = '0;
        put_load_id();
        put_viewport('0, '0, 32'sh0002_0000, 32'sh0002_0000);
        put_color(24'h00_ff_00);
        put_vertex(32'sh000a_0000, 32'shfffa_0000, '0, 32'sh0002_0000, 1'b1);
        put_vertex(32'shfffd_0000, 32'sh0005_0000, '0, '0, 1'b1);
        put_end();
        run_stream(1'b0);

        // colour change between vertices
        wp = '0;
        put_load_id();
        put_viewport(32'sh0008_0000, 32'sh0004_0000, 32'sh0040_0000, 32'sh0030_0000);
        put_color(24'h12_34_56);
        for (int n = 0; n < 3; n++)
        begin
            if (n == 2)
                put_color(24'hab_cd_ef);
            put_vertex(range_rand(32'shffc0_0000, 32'h0080_0000),
                       range_rand(32'shffc0_0000, 32'h0080_0000), '0,
                       gl_math_pkg::FX_ONE, 1'b1);
        end
        put_end();
        run_stream(1'b0);

        // data word where a command belongs so the vertex behind it never runs
        wp = '0;
        put_load_id();
        put_word(32'h0000_1234);
        put_vertex(gl_math_pkg::FX_ONE, gl_math_pkg::FX_ONE, '0, gl_math_pkg::FX_ONE, 1'b0);
        put_end();
        run_stream(1'b1);
        repeat (150) @(posedge clk1);
        #1;
        assert (fault && !busy)
            else
            begin
                $display("error fault %h busy %h after hold", fault, busy);
                fail_run();
            end

        // fresh start clears fault and then done
        wp = '0;
        put_end();
        run_stream(1'b0);
        run_stream(1'b0);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
hw/gl_math_pkg.sv
hw/gl_cmd_pkg.sv
hw/gl_xform_if.sv
hw/gl_cmd_ram.sv
hw/gl_fetch.sv
hw/gl_decode.sv
hw/gl_matrix_unit.sv
hw/gl_persp_view.sv
hw/gl_core.sv
testbench/tb_gl_core.sv

// File: Makefile
TOP := tb_gl_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module gl_core

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
